// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal -j 0
TOP       := tb_game_top
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) game_macros.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== draw_players.sv ====
// one-cycle stage painting both player bars on the fixed row band
// player 2 is drawn over player 1 where the bars overlap

`timescale 1ns/1ps

`include "game_macros.svh"

module draw_players (
    input  logic        clk_40,
    input  logic        rst,
    vga_if.in           vga_in,
    vga_if.out          vga_out,
    input  logic [11:0] xpos_player1,
    input  logic [11:0] xpos_player2
);

    logic        bar_row;
    logic [12:0] hpos;
    logic [12:0] p1_end;
    logic [12:0] p2_end;
    logic        in_p1;
    logic        in_p2;

    // both bars share the same vertical window
    assign bar_row = !vga_in.hblnk && !vga_in.vblnk
                     && (vga_in.vcount >= `PLAYER_Y)
                     && (vga_in.vcount < `PLAYER_Y + `PLAYER_H);

    assign hpos   = {2'b00, vga_in.hcount};
    assign p1_end = {1'b0, xpos_player1} + 13'(`PLAYER_W);
    assign p2_end = {1'b0, xpos_player2} + 13'(`PLAYER_W);

    assign in_p1 = bar_row && (hpos >= {1'b0, xpos_player1}) && (hpos < p1_end);
    assign in_p2 = bar_row && (hpos >= {1'b0, xpos_player2}) && (hpos < p2_end);

    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            if (in_p2) begin
                vga_out.rgb <= `COLOR_P2;
            end else if (in_p1) begin
                vga_out.rgb <= `COLOR_P1;
            end else begin
                vga_out.rgb <= vga_in.rgb;  // rectangle or level background
            end
        end
    end

endmodule

// ==== draw_rect.sv ====
// one-cycle stage painting a solid rectangle, top left corner at the register position
// a rectangle running past the visible edge is simply clipped by blanking

`timescale 1ns/1ps

`include "game_macros.svh"

module draw_rect (
    input  logic        clk_40,
    input  logic        rst,
    vga_if.in           vga_in,
    vga_if.out          vga_out,
    input  logic [11:0] xpos_rect,
    input  logic [11:0] ypos_rect
);

    logic [12:0] x_end;
    logic [12:0] y_end;
    logic        in_rect;

    // one extra bit so a position near 4095 cannot wrap the right or bottom edge
    assign x_end = {1'b0, xpos_rect} + 13'(`RECT_W);
    assign y_end = {1'b0, ypos_rect} + 13'(`RECT_H);

    assign in_rect = !vga_in.hblnk && !vga_in.vblnk
                     && ({2'b00, vga_in.hcount} >= {1'b0, xpos_rect})
                     && ({2'b00, vga_in.hcount} < x_end)
                     && ({2'b00, vga_in.vcount} >= {1'b0, ypos_rect})
                     && ({2'b00, vga_in.vcount} < y_end);

    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= in_rect ? `COLOR_RECT : vga_in.rgb;
        end
    end

endmodule

// ==== game_checker.sv ====
// bound into game_top, checks only the APB response and the video outputs
// assertions are held off while rst is high

`timescale 1ns/1ps

module game_checker (
    input logic        clk_40,
    input logic        rst,
    input logic        psel,
    input logic        penable,
    input logic        pslverr,
    input logic        hsync,
    input logic        vsync,
    input logic        hblnk,
    input logic        vblnk,
    input logic [11:0] rgb
);

    // an error response only exists in the access phase
    a_slverr_in_access: assert property (
        @(posedge clk_40) disable iff (rst) pslverr |-> (psel && penable)
    ) else $error("pslverr raised outside the APB access phase");

    a_black_in_blank: assert property (
        @(posedge clk_40) disable iff (rst) (hblnk || vblnk) |-> (rgb == 12'h000)
    ) else $error("rgb is not black during blanking");

    a_hsync_in_hblank: assert property (
        @(posedge clk_40) disable iff (rst) hsync |-> hblnk
    ) else $error("hsync active while the line is visible");

    a_vsync_in_vblank: assert property (
        @(posedge clk_40) disable iff (rst) vsync |-> vblnk
    ) else $error("vsync active outside vertical blanking");

endmodule

bind game_top game_checker i_checker (
    .clk_40  (clk_40),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .hsync   (hsync),
    .vsync   (vsync),
    .hblnk   (hblnk),
    .vblnk   (vblnk),
    .rgb     (rgb)
);

// ==== game_macros.svh ====
// display timing is fixed SVGA 800x600 at a 40 MHz pixel clock, syncs are active high
// all colours are 12-bit rgb, 4 bits per channel

`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

`define H_VISIBLE     800
`define H_TOTAL       1056
`define H_SYNC_START  840
`define H_SYNC_END    968

`define V_VISIBLE     600
`define V_TOTAL       628
`define V_SYNC_START  601
`define V_SYNC_END    605

`define RECT_W        48
`define RECT_H        32

`define PLAYER_W      64
`define PLAYER_H      8
`define PLAYER_Y      16   // bars cover rows 16 to 23

`define TITLE_Y0      4
`define TITLE_Y1      12   // first row below the title band

`define COLOR_START   12'h135
`define COLOR_LEVEL   12'h262
`define COLOR_FINISH  12'h512
`define COLOR_TITLE   12'hfd0
`define COLOR_RECT    12'h0cf
`define COLOR_P1      12'hf40
`define COLOR_P2      12'h4f4

`endif

// ==== game_pkg.sv ====
// shared types for the game display and its register block
// register addresses are word indices, i.e. paddr[4:2]

package game_pkg;

    // screen shown by the selector, code 3 is never stored
    typedef enum logic [1:0] {
        START   = 2'd0,
        LEVEL_1 = 2'd1,
        FINISH  = 2'd2
    } game_state_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_phase_t;

    // byte addresses 0x0, 0x4, 0x8 and 0xC
    typedef enum logic [2:0] {
        REG_STATE = 3'd0,
        REG_RECT  = 3'd1,  // x in 11:0, y in 27:16
        REG_P1    = 3'd2,
        REG_P2    = 3'd3
    } reg_addr_t;

endpackage

// ==== game_regs_apb.sv ====
// zero wait state APB slave, pready is tied high
// misaligned or unmapped addresses complete with pslverr and read as zero

`timescale 1ns/1ps

module game_regs_apb
    import game_pkg::*;
(
    input  logic        clk_40,
    input  logic        rst,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output game_state_t game_state,
    output logic [11:0] xpos_rect,
    output logic [11:0] ypos_rect,
    output logic [11:0] xpos_player1,
    output logic [11:0] xpos_player2
);

    apb_phase_t  phase;
    reg_addr_t   reg_sel;
    logic        addr_ok;
    logic [31:0] rd_mux;

    // the bus phase follows directly from psel and penable
    always_comb begin
        if (!psel) begin
            phase = IDLE;
        end else if (!penable) begin
            phase = SETUP;
        end else begin
            phase = ACCESS;
        end
    end

    always_comb begin
        reg_sel = reg_addr_t'(paddr[4:2]);
        addr_ok = (paddr[1:0] == 2'b00);
        rd_mux  = '0;
        case (reg_sel)
            REG_STATE: rd_mux = {30'd0, game_state};
            REG_RECT:  rd_mux = {4'd0, ypos_rect, 4'd0, xpos_rect};
            REG_P1:    rd_mux = {20'd0, xpos_player1};
            REG_P2:    rd_mux = {20'd0, xpos_player2};
            default:   addr_ok = 1'b0;  // word 4 and above are unmapped
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = (phase == ACCESS) && !addr_ok;
    assign prdata  = ((phase == ACCESS) && addr_ok) ? rd_mux : '0;

    always_ff @(posedge clk_40) begin
        if (rst) begin
            game_state   <= START;
            xpos_rect    <= '0;
            ypos_rect    <= '0;
            xpos_player1 <= '0;
            xpos_player2 <= '0;
        end else if ((phase == ACCESS) && pwrite && addr_ok) begin
            case (reg_sel)
                REG_STATE: begin
                    // code 3 has no screen and falls back to the start screen
                    if (pwdata[1:0] == 2'd3) begin
                        game_state <= START;
                    end else begin
                        game_state <= game_state_t'(pwdata[1:0]);
                    end
                end
                REG_RECT: begin
                    xpos_rect <= pwdata[11:0];
                    ypos_rect <= pwdata[27:16];
                end
                REG_P1:  xpos_player1 <= pwdata[11:0];
                REG_P2:  xpos_player2 <= pwdata[11:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== game_top.sv ====
// video outputs lag the raster counters by 5 clocks, syncs are active high
// APB never stalls, pready is constant high

`timescale 1ns/1ps

module game_top
    import game_pkg::*;
(
    input  logic        clk_40,
    input  logic        rst,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk,
    output logic [11:0] rgb
);

    vga_if timing_bus();
    vga_if screen_bus();

    game_state_t game_state;
    logic [11:0] xpos_rect;
    logic [11:0] ypos_rect;
    logic [11:0] xpos_player1;
    logic [11:0] xpos_player2;

    vga_timing u_vga_timing (
        .clk_40  (clk_40),
        .rst     (rst),
        .vga_out (timing_bus)
    );

    game_regs_apb u_game_regs_apb (
        .clk_40       (clk_40),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .game_state   (game_state),
        .xpos_rect    (xpos_rect),
        .ypos_rect    (ypos_rect),
        .xpos_player1 (xpos_player1),
        .xpos_player2 (xpos_player2)
    );

    start_game u_start_game (
        .clk_40       (clk_40),
        .rst          (rst),
        .game_state   (game_state),
        .xpos_rect    (xpos_rect),
        .ypos_rect    (ypos_rect),
        .xpos_player1 (xpos_player1),
        .xpos_player2 (xpos_player2),
        .vga_in       (timing_bus),
        .vga_out      (screen_bus)
    );

    // pixel counts stay internal, the monitor only needs syncs and colour
    assign hsync = screen_bus.hsync;
    assign vsync = screen_bus.vsync;
    assign hblnk = screen_bus.hblnk;
    assign vblnk = screen_bus.vblnk;
    assign rgb   = screen_bus.rgb;

endmodule

// ==== project.f ====
+incdir+.
game_pkg.sv
vga_if.sv
vga_timing.sv
game_regs_apb.sv
draw_rect.sv
draw_players.sv
start_game.sv
game_top.sv
game_checker.sv
tb_game_top.sv

// ==== start_game.sv ====
// every screen path is 3 cycles deep, plus the output register, 4 cycles in total
// the selected screen follows game_state on the next pixel, even in mid-frame

`timescale 1ns/1ps

`include "game_macros.svh"

module start_game
    import game_pkg::*;
(
    input  logic        clk_40,
    input  logic        rst,
    input  game_state_t game_state,
    input  logic [11:0] xpos_rect,
    input  logic [11:0] ypos_rect,
    input  logic [11:0] xpos_player1,
    input  logic [11:0] xpos_player2,
    vga_if.in           vga_in,
    vga_if.out          vga_out
);

    vga_if level_bg();
    vga_if rect_bus();
    vga_if level_bus();

    logic        visible;
    logic        title_row;
    logic [11:0] start_rgb [3];   // start screen colour and its two pad stages
    logic [11:0] finish_rgb [3];
    logic [11:0] sel_rgb;

    assign visible   = !vga_in.hblnk && !vga_in.vblnk;
    assign title_row = (vga_in.vcount >= `TITLE_Y0) && (vga_in.vcount < `TITLE_Y1);

    // background stage for all three screens, they share one position register
    always_ff @(posedge clk_40) begin
        if (rst) begin
            level_bg.hcount <= '0;
            level_bg.vcount <= '0;
            level_bg.hsync  <= 1'b0;
            level_bg.vsync  <= 1'b0;
            level_bg.hblnk  <= 1'b0;
            level_bg.vblnk  <= 1'b0;
            level_bg.rgb    <= '0;
            start_rgb[0]    <= '0;
            finish_rgb[0]   <= '0;
        end else begin
            level_bg.hcount <= vga_in.hcount;
            level_bg.vcount <= vga_in.vcount;
            level_bg.hsync  <= vga_in.hsync;
            level_bg.vsync  <= vga_in.vsync;
            level_bg.hblnk  <= vga_in.hblnk;
            level_bg.vblnk  <= vga_in.vblnk;
            level_bg.rgb    <= visible ? `COLOR_LEVEL : 12'h000;
            start_rgb[0]    <= !visible ? 12'h000 : (title_row ? `COLOR_TITLE : `COLOR_START);
            finish_rgb[0]   <= !visible ? 12'h000 : (title_row ? `COLOR_TITLE : `COLOR_FINISH);
        end
    end

    // start and finish colours wait two cycles while the level chain draws
    always_ff @(posedge clk_40) begin
        if (rst) begin
            start_rgb[1]  <= '0;
            start_rgb[2]  <= '0;
            finish_rgb[1] <= '0;
            finish_rgb[2] <= '0;
        end else begin
            start_rgb[1]  <= start_rgb[0];
            start_rgb[2]  <= start_rgb[1];
            finish_rgb[1] <= finish_rgb[0];
            finish_rgb[2] <= finish_rgb[1];
        end
    end

    draw_rect u_draw_rect (
        .clk_40    (clk_40),
        .rst       (rst),
        .vga_in    (level_bg),
        .vga_out   (rect_bus),
        .xpos_rect (xpos_rect),
        .ypos_rect (ypos_rect)
    );

    draw_players u_draw_players (
        .clk_40       (clk_40),
        .rst          (rst),
        .vga_in       (rect_bus),
        .vga_out      (level_bus),
        .xpos_player1 (xpos_player1),
        .xpos_player2 (xpos_player2)
    );

    // equal depth on every path, so only the colour differs between screens
    always_comb begin
        case (game_state)
            START:   sel_rgb = start_rgb[2];
            LEVEL_1: sel_rgb = level_bus.rgb;
            FINISH:  sel_rgb = finish_rgb[2];
            default: sel_rgb = start_rgb[2];
        endcase
    end

    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= level_bus.hcount;
            vga_out.vcount <= level_bus.vcount;
            vga_out.hsync  <= level_bus.hsync;
            vga_out.vsync  <= level_bus.vsync;
            vga_out.hblnk  <= level_bus.hblnk;
            vga_out.vblnk  <= level_bus.vblnk;
            vga_out.rgb    <= sel_rgb;
        end
    end

endmodule

// ==== tb_game_top.sv ====
// scans only the first SCAN_LINES visible lines of each frame, so rectangles stay near the top
// pixel x and y are recovered by counting visible pixels and lines after a frame start

`timescale 1ns/1ps

`include "game_macros.svh"

module tb_game_top
    import game_pkg::*;
();

    localparam int ROWS          = 6;
    localparam int SCAN_LINES    = 40;
    localparam int APB_TIMEOUT   = 16;
    localparam int FRAME_TIMEOUT = `H_TOTAL * `V_TOTAL + 4 * `H_TOTAL;

    logic        clk_40;
    logic        rst;
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [11:0] rgb;

    string       row_name  [ROWS];
    int          row_state [ROWS];   // code as written, 3 is the unused one
    int          row_rx    [ROWS];
    int          row_ry    [ROWS];
    int          row_p1    [ROWS];
    int          row_p2    [ROWS];
    logic [31:0] rdata;
    logic        err;

    game_top i_dut (
        .clk_40  (clk_40),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hsync   (hsync),
        .vsync   (vsync),
        .hblnk   (hblnk),
        .vblnk   (vblnk),
        .rgb     (rgb)
    );

    always #4 clk_40 = ~clk_40;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // access phase is held until pready, then the bus returns to idle
    task automatic complete_access(output logic [31:0] data, output logic slverr);
        int waited;
        waited = 0;
        @(negedge clk_40);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin
            if (waited >= APB_TIMEOUT) begin
                stop_with_failure("APB transfer never saw pready");
            end
            @(negedge clk_40);
            #1;
            waited++;
        end
        data = prdata;
        slverr = pslverr;
        @(negedge clk_40);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused_data;
        @(negedge clk_40);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        complete_access(unused_data, slverr);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(negedge clk_40);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        complete_access(data, slverr);
    endtask

    // pixel rule, player 2 over player 1 over the rectangle
    function automatic logic [11:0] expected_pixel(input int state, input int rx, input int ry,
                                                   input int p1, input int p2,
                                                   input int x, input int y);
        logic        bar_row;
        logic [11:0] colour;
        bar_row = (y >= `PLAYER_Y) && (y < `PLAYER_Y + `PLAYER_H);
        if (state == int'(LEVEL_1)) begin
            if (bar_row && (x >= p2) && (x < p2 + `PLAYER_W)) begin
                colour = `COLOR_P2;
            end else if (bar_row && (x >= p1) && (x < p1 + `PLAYER_W)) begin
                colour = `COLOR_P1;
            end else if ((x >= rx) && (x < rx + `RECT_W) && (y >= ry) && (y < ry + `RECT_H)) begin
                colour = `COLOR_RECT;
            end else begin
                colour = `COLOR_LEVEL;
            end
        end else if ((y >= `TITLE_Y0) && (y < `TITLE_Y1)) begin
            colour = `COLOR_TITLE;
        end else if (state == int'(FINISH)) begin
            colour = `COLOR_FINISH;
        end else begin
            colour = `COLOR_START;  // START and the code 3 fallback
        end
        return colour;
    endfunction

    // returns on the sample that holds pixel (0,0), after the whole vertical sync pulse
    task automatic wait_frame_start(input string name);
        int   waited;
        int   vsync_cycles;
        logic prev_vblnk;
        waited = 0;
        vsync_cycles = 0;
        prev_vblnk = vblnk;
        @(negedge clk_40);
        while (!(prev_vblnk && !vblnk && !hblnk)) begin
            if (waited >= FRAME_TIMEOUT) begin
                stop_with_failure($sformatf("%s: no frame start within one frame period", name));
            end
            if (vsync) begin
                vsync_cycles++;
            end
            prev_vblnk = vblnk;
            @(negedge clk_40);
            waited++;
        end
        check_value({name, " vsync cycles"},
                    32'((`V_SYNC_END - `V_SYNC_START) * `H_TOTAL), 32'(vsync_cycles));
    endtask

    task automatic scan_lines(input int row);
        int          x;
        int          y;
        int          blank_x;
        int          guard;
        logic        prev_hblnk;
        logic        exp_hsync;
        logic [11:0] exp_rgb;
        string       label;
        x = 0;
        y = 0;
        blank_x = 0;
        guard = 0;
        prev_hblnk = 1'b0;
        label = $sformatf("%s line 0", row_name[row]);
        while (y < SCAN_LINES) begin
            if (hblnk || vblnk) begin
                check_value(label, 32'd0, {20'd0, rgb});
                // hsync sits inside the blank at a fixed offset from the end of the line
                exp_hsync = (blank_x >= `H_SYNC_START - `H_VISIBLE)
                            && (blank_x < `H_SYNC_END - `H_VISIBLE);
                check_value({label, " syncs"}, {30'd0, exp_hsync, 1'b0}, {30'd0, hsync, vsync});
                blank_x++;
                if (hblnk && !prev_hblnk) begin  // end of a visible line
                    y++;
                    x = 0;
                    label = $sformatf("%s line %0d", row_name[row], y);
                end
            end else begin
                exp_rgb = expected_pixel(row_state[row], row_rx[row], row_ry[row],
                                         row_p1[row], row_p2[row], x, y);
                check_value(label, {20'd0, exp_rgb}, {20'd0, rgb});
                check_value({label, " syncs"}, 32'd0, {30'd0, hsync, vsync});
                blank_x = 0;
                x++;
            end
            prev_hblnk = hblnk;
            guard++;
            if (guard > (SCAN_LINES + 1) * `H_TOTAL) begin
                stop_with_failure($sformatf("%s: scan did not reach the last line", row_name[row]));
            end
            @(negedge clk_40);
        end
    endtask

    task automatic fill_table();
        row_name[0] = "start";
        row_state[0] = int'(START);
        row_name[1] = "level_random";
        row_state[1] = int'(LEVEL_1);
        row_name[2] = "level_overlap";
        row_state[2] = int'(LEVEL_1);
        row_name[3] = "finish";
        row_state[3] = int'(FINISH);
        row_name[4] = "state3_start";
        row_state[4] = 3;
        row_name[5] = "level_edges";
        row_state[5] = int'(LEVEL_1);
        for (int i = 0; i < ROWS; i++) begin
            row_rx[i] = int'($urandom % 700);
            row_ry[i] = 2 + int'($urandom % 6);  // bottom edge stays inside the scan
            row_p1[i] = int'($urandom % 737);
            row_p2[i] = int'($urandom % 737);
        end
        // player 2 half over player 1, rectangle under both bars
        row_p2[2] = row_p1[2] + 32;
        row_rx[2] = row_p1[2] + 16;
        row_ry[2] = 4;
        // rectangle clipped at the right edge, bars at both ends of the line
        row_rx[5] = 776;
        row_ry[5] = 0;
        row_p1[5] = 0;
        row_p2[5] = `H_VISIBLE - `PLAYER_W;
    endtask

    task automatic apply_row(input int row);
        apb_write(5'h00, 32'(row_state[row]), err);
        check_value({row_name[row], " state pslverr"}, 32'd0, {31'd0, err});
        apb_write(5'h04, {4'd0, 12'(row_ry[row]), 4'd0, 12'(row_rx[row])}, err);
        check_value({row_name[row], " rect pslverr"}, 32'd0, {31'd0, err});
        apb_write(5'h08, 32'(row_p1[row]), err);
        check_value({row_name[row], " p1 pslverr"}, 32'd0, {31'd0, err});
        apb_write(5'h0c, 32'(row_p2[row]), err);
        check_value({row_name[row], " p2 pslverr"}, 32'd0, {31'd0, err});
    endtask

    initial begin
        void'($urandom(32'h23f4));
        clk_40 = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        fill_table();
        repeat (2) @(negedge clk_40);
        check_value("reset video", 32'd0, {16'd0, hsync, vsync, hblnk, vblnk, rgb});
        check_value("reset prdata", 32'd0, prdata);
        check_value("reset pslverr", 32'd0, {31'd0, pslverr});
        rst = 1'b0;
        wait_frame_start("first frame");

        // register readback, unmapped word and the state code 3
        apb_write(5'h04, 32'hfabc_f123, err);
        apb_read(5'h04, rdata, err);
        check_value("rect readback", 32'h0abc_0123, rdata);
        apb_write(5'h08, 32'hffff_f2a5, err);
        apb_read(5'h08, rdata, err);
        check_value("p1 readback", 32'h0000_02a5, rdata);
        apb_write(5'h0c, 32'h0000_0155, err);
        apb_read(5'h0c, rdata, err);
        check_value("p2 readback", 32'h0000_0155, rdata);
        apb_write(5'h00, 32'd2, err);
        apb_read(5'h00, rdata, err);
        check_value("state readback", 32'd2, rdata);
        check_value("valid pslverr", 32'd0, {31'd0, err});
        apb_write(5'h00, 32'd3, err);
        apb_read(5'h00, rdata, err);
        check_value("state3 readback", 32'(START), rdata);
        apb_write(5'h10, 32'hdead_beef, err);
        check_value("unmapped write pslverr", 32'd1, {31'd0, err});
        apb_read(5'h10, rdata, err);
        check_value("unmapped read pslverr", 32'd1, {31'd0, err});

        // each row is written while the raster runs, the next full frame shows it
        for (int i = 0; i < ROWS; i++) begin
            apply_row(i);
            wait_frame_start(row_name[i]);
            scan_lines(i);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== vga_if.sv ====
// video bus passed between drawing stages, all signals move together
// counts are 11 bits, enough for the 1056 x 628 raster

`timescale 1ns/1ps

interface vga_if;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [11:0] rgb;

    // a stage reads its upstream bus through in and drives the next one through out
    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

// ==== vga_timing.sv ====
// free-running SVGA raster, outputs are registered one cycle after the counters
// rgb is driven black here, the screen stages paint the picture

`timescale 1ns/1ps

`include "game_macros.svh"

module vga_timing (
    input  logic clk_40,
    input  logic rst,
    vga_if.out   vga_out
);

    logic [10:0] hcnt;
    logic [10:0] vcnt;
    logic        line_end;

    assign line_end = (hcnt == `H_TOTAL - 1);

    always_ff @(posedge clk_40) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (line_end) begin
            hcnt <= '0;
            // vertical counter steps once per line
            if (vcnt == `V_TOTAL - 1) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 11'd1;
            end
        end else begin
            hcnt <= hcnt + 11'd1;
        end
    end

    // decode from the current count so position and flags stay aligned
    always_ff @(posedge clk_40) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= hcnt;
            vga_out.vcount <= vcnt;
            vga_out.hsync  <= (hcnt >= `H_SYNC_START) && (hcnt < `H_SYNC_END);
            vga_out.vsync  <= (vcnt >= `V_SYNC_START) && (vcnt < `V_SYNC_END);
            vga_out.hblnk  <= (hcnt >= `H_VISIBLE);
            vga_out.vblnk  <= (vcnt >= `V_VISIBLE);
            vga_out.rgb    <= '0;  // no picture at this stage
        end
    end

endmodule
